// ==== tb.f ====
design/rv_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/int_alu.sv
design/muldiv_unit.sv
design/exec_sequencer.sv
design/exec_core.sv
bench/clk_rst_gen.sv
bench/tb_exec_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_exec_core
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;

    import rv_pkg::*;

    logic        clk, arst_n;
    logic        instr_valid_i;
    logic [31:0] instruction_i;
    logic        busy_o, done_o;
    retire_t     retire_o;

    logic [31:0] shadow [32];
    logic [31:0] lfsr_state = 32'h8d90_c263;
    retire_t     exp_q [$];
    int          error_count = 0;
    int          timeout_count = 0;
    int          retire_count = 0;
    logic        aborted = 1'b0;

    clk_rst_gen u_clk_rst (.clk_o(clk), .arst_n_o(arst_n));

    exec_core dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_valid_i (instr_valid_i),
        .instruction_i (instruction_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .retire_o      (retire_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_ARITH};
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : shadow[idx];
    endfunction

    function automatic logic [31:0] base_op(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            FUNCT3_ADD_SUB: return alt ? a - b : a + b;
            FUNCT3_SLL:     return a << b[4:0];
            FUNCT3_SLT:     return {31'd0, ($signed(a) < $signed(b))};
            FUNCT3_SLTU:    return {31'd0, (a < b)};
            FUNCT3_XOR:     return a ^ b;
            FUNCT3_SRL_SRA: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            FUNCT3_OR:      return a | b;
            default:        return a & b;
        endcase
    endfunction

    function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] sa, sb, za, zb;
        logic        ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        za  = {32'd0, a};
        zb  = {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            FUNCT3_MUL:    return 32'(za * zb);
            FUNCT3_MULH:   return 32'((sa * sb) >> 32);
            FUNCT3_MULHSU: return 32'((sa * zb) >> 32);
            FUNCT3_MULHU:  return 32'((za * zb) >> 32);
            FUNCT3_DIV:    return (b == 0) ? '1 : ovf ? a : 32'($signed(a) / $signed(b));
            FUNCT3_DIVU:   return (b == 0) ? '1 : a / b;
            FUNCT3_REM:    return (b == 0) ? a : ovf ? 32'd0 : 32'($signed(a) % $signed(b));
            default:       return (b == 0) ? a : a % b;
        endcase
    endfunction

    // Expected retire from the ISA rules and the shadow registers
    function automatic retire_t ref_retire(input logic [31:0] ins);
        retire_t     r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a, b, imm;
        r   = '0;
        r.rd = ins[11:7];
        f7  = ins[31:25];
        f3  = ins[14:12];
        a   = reg_value(ins[19:15]);
        b   = reg_value(ins[24:20]);
        imm = {{20{ins[31]}}, ins[31:20]};
        r.illegal = 1'b1;
        case (ins[6:0])
            OPCODE_LUI: begin
                r.illegal = 1'b0;
                r.value   = {ins[31:12], 12'd0};
            end
            OPCODE_IMM_ARITH: begin
                if (!((f3 == FUNCT3_SLL && f7 != FUNCT7_ADD) ||
                      (f3 == FUNCT3_SRL_SRA && f7 != FUNCT7_ADD && f7 != FUNCT7_SUB))) begin
                    r.illegal = 1'b0;
                    r.value   = base_op(f3, (f3 == FUNCT3_SRL_SRA) && (f7 == FUNCT7_SUB), a, imm);
                end
            end
            OPCODE_ARITH: begin
                if (f7 == FUNCT7_ADD) begin
                    r.illegal = 1'b0;
                    r.value   = base_op(f3, 1'b0, a, b);
                end else if (f7 == FUNCT7_SUB &&
                             (f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA)) begin
                    r.illegal = 1'b0;
                    r.value   = base_op(f3, 1'b1, a, b);
                end else if (f7 == FUNCT7_MUL_DIV_REM) begin
                    r.illegal = 1'b0;
                    r.value   = muldiv_ref(f3, a, b);
                end
            end
            default: r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Compare each retire and update the shadow registers
    always @(negedge clk) begin
        retire_t exp;
        if (arst_n && done_o) begin
            if (exp_q.size() == 0) begin
                $display("Retire seen at %0t ns with no instruction pending", $time);
                error_count++;
            end else begin
                exp = exp_q.pop_front();
                check_equal("retire rd", 32'(retire_o.rd), 32'(exp.rd));
                check_equal("retire value", retire_o.value, exp.value);
                check_equal("retire illegal", 32'(retire_o.illegal), 32'(exp.illegal));
                if (!exp.illegal && exp.rd != 5'd0) begin
                    shadow[exp.rd] = exp.value;
                end
            end
            retire_count++;
        end
    end

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_o && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy_o) begin
            $display("Timed out at %0t ns waiting for busy_o to fall", $time);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_retire(input int start);
        int n;
        n = 0;
        while (retire_count == start && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (retire_count == start) begin
            $display("Timed out at %0t ns waiting for done_o", $time);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic send(input logic [31:0] ins);
        int start;
        if (aborted) return;
        wait_idle();
        if (aborted) return;
        exp_q.push_back(ref_retire(ins));
        start         = retire_count;
        instr_valid_i = 1'b1;
        instruction_i = ins;
        @(posedge clk);
        #1 instr_valid_i = 1'b0;
        wait_retire(start);
    endtask

    // LUI then ADDI with the upper part rounded for the sign of the low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        send({upper[31:12], rd, OPCODE_LUI});
        send(enc_i(value[11:0], rd, FUNCT3_ADD_SUB, rd, OPCODE_IMM_ARITH));
    endtask

    task automatic readback_all();
        for (int r = 1; r < 32; r++) begin
            send(enc_i(12'd0, 5'(r), FUNCT3_ADD_SUB, 5'(r), OPCODE_IMM_ARITH));
        end
    endtask

    initial begin
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [6:0]  bad_opc [5];
        int          n;
        int          start;
        instr_valid_i = 1'b0;
        instruction_i = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1110011};
        n = 0;
        while (!arst_n && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n) begin
            $display("Timed out at %0t ns waiting for reset release", $time);
            timeout_count++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #1;
        check_equal("busy_o after reset", 32'(busy_o), 32'd0);
        check_equal("done_o after reset", 32'(done_o), 32'd0);

        // ADDI constants, then x0 write attempt and readback
        for (int r = 1; r < 32; r++) begin
            send(enc_i(12'(take_bits(12)), 5'd0, FUNCT3_ADD_SUB, 5'(r), OPCODE_IMM_ARITH));
        end
        send(enc_i(12'h5a5, 5'd3, FUNCT3_ADD_SUB, 5'd0, OPCODE_IMM_ARITH));
        send(enc_r(FUNCT7_ADD, 5'd0, 5'd0, FUNCT3_ADD_SUB, 5'd8));

        for (int i = 0; i < 40; i++) begin
            f3    = 3'(take_bits(3));
            imm12 = 12'(take_bits(12));
            if (f3 == FUNCT3_SLL) imm12 = {7'd0, imm12[4:0]};
            if (f3 == FUNCT3_SRL_SRA) imm12 = {1'b0, imm12[10], 5'd0, imm12[4:0]};
            send(enc_i(imm12, 5'(take_bits(5)), f3, 5'(take_bits(5)), OPCODE_IMM_ARITH));
        end

        for (int r = 1; r < 32; r++) begin
            load_reg(5'(r), take_bits(32));
        end
        for (int i = 0; i < 60; i++) begin
            f3 = 3'(take_bits(3));
            f7 = (take_bits(1) == 1 && (f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA)) ?
                 FUNCT7_SUB : FUNCT7_ADD;
            send(enc_r(f7, 5'(take_bits(5)), 5'(take_bits(5)), f3, 5'(take_bits(5))));
        end

        // Corner operands in x1 to x5 against every M op
        load_reg(5'd1, 32'd0);
        load_reg(5'd2, 32'hffff_ffff);
        load_reg(5'd3, 32'h8000_0000);
        load_reg(5'd4, 32'd1);
        load_reg(5'd5, 32'h7fff_ffff);
        for (int op = 0; op < 8; op++) begin
            for (int ra = 1; ra < 6; ra++) begin
                for (int rb = 1; rb < 6; rb++) begin
                    send(enc_r(FUNCT7_MUL_DIV_REM, 5'(rb), 5'(ra), 3'(op),
                               5'd6 + 5'(take_bits(4))));
                end
            end
        end
        for (int i = 0; i < 32; i++) begin
            load_reg(5'd10, take_bits(32));
            load_reg(5'd11, take_bits(32));
            send(enc_r(FUNCT7_MUL_DIV_REM, 5'd11, 5'd10, 3'(take_bits(3)), 5'd12));
        end
        for (int i = 0; i < 8; i++) begin
            send({20'(take_bits(20)), 5'(take_bits(5)), OPCODE_LUI});
        end

        // Unsupported opcodes and bad funct7
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 5; k++) begin
                send({25'(take_bits(25)), bad_opc[k]});
            end
            send(enc_r(7'b0000010, 5'd1, 5'd2, 3'(take_bits(3)), 5'(take_bits(5))));
            send(enc_r(FUNCT7_SUB, 5'd1, 5'd2, FUNCT3_XOR, 5'(take_bits(5))));
            send(enc_i({FUNCT7_SUB, 5'd3}, 5'd2, FUNCT3_SLL, 5'd7, OPCODE_IMM_ARITH));
            send(enc_i({FUNCT7_MUL_DIV_REM, 5'd3}, 5'd2, FUNCT3_SRL_SRA, 5'd7,
                       OPCODE_IMM_ARITH));
        end
        readback_all();

        // Strobe during a divide must be dropped
        if (!aborted) begin
            wait_idle();
            exp_q.push_back(ref_retire(enc_r(FUNCT7_MUL_DIV_REM, 5'd4, 5'd3, FUNCT3_DIV, 5'd9)));
            start         = retire_count;
            instr_valid_i = 1'b1;
            instruction_i = enc_r(FUNCT7_MUL_DIV_REM, 5'd4, 5'd3, FUNCT3_DIV, 5'd9);
            @(posedge clk);
            #1 instr_valid_i = 1'b0;
            repeat (3) @(posedge clk);
            #1;
            check_equal("busy_o during divide", 32'(busy_o), 32'd1);
            instr_valid_i = 1'b1;
            instruction_i = enc_i(12'h123, 5'd0, FUNCT3_ADD_SUB, 5'd13, OPCODE_IMM_ARITH);
            @(posedge clk);
            #1 instr_valid_i = 1'b0;
            wait_retire(start);
            repeat (4) @(posedge clk);
            #1;
            check_equal("retire count after stray strobe", 32'(retire_count), 32'(start + 1));
            readback_all();
        end

        check_equal("pending retires", 32'(exp_q.size()), 32'd0);
        $display("errors: %0d  timeouts: %0d  retired: %0d",
                 error_count, timeout_count, retire_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

    // 10 ns period
    always #5 clk_o = ~clk_o;

endmodule

// ==== design/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instruction_i,
    output logic            busy_o,
    output logic            done_o,
    output rv_pkg::retire_t retire_o
);

    import rv_pkg::*;

    decode_t     decode;
    alu_op_e     alu_op;
    logic [4:0]  rs1_addr, rs2_addr, rf_wr_addr;
    logic [31:0] rs1_data, rs2_data, rf_wr_data;
    logic [31:0] op_a, op_b, alu_result, md_result;
    logic        md_start, md_done, rf_wr_en;

    instr_decoder u_decoder (
        .instruction_i (instruction_i),
        .decode_o      (decode)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd_addr1_i (rs1_addr),
        .rd_addr2_i (rs2_addr),
        .rd_data1_o (rs1_data),
        .rd_data2_o (rs2_data),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data)
    );

    int_alu u_alu (
        .op_i     (alu_op),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .result_o (alu_result)
    );

    muldiv_unit u_muldiv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (md_start),
        .op_i     (alu_op),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .done_o   (md_done),
        .result_o (md_result)
    );

    exec_sequencer u_sequencer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .decode_i      (decode),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .alu_op_o      (alu_op),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .alu_result_i  (alu_result),
        .md_start_o    (md_start),
        .md_done_i     (md_done),
        .md_result_i   (md_result),
        .rf_wr_en_o    (rf_wr_en),
        .rf_wr_addr_o  (rf_wr_addr),
        .rf_wr_data_o  (rf_wr_data),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .retire_o      (retire_o)
    );

endmodule

// ==== design/exec_sequencer.sv ====
`timescale 1ns/1ps

module exec_sequencer (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            instr_valid_i,
    input  rv_pkg::decode_t decode_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [31:0]     rs1_data_i,
    input  logic [31:0]     rs2_data_i,
    output rv_pkg::alu_op_e alu_op_o,
    output logic [31:0]     op_a_o,
    output logic [31:0]     op_b_o,
    input  logic [31:0]     alu_result_i,
    output logic            md_start_o,
    input  logic            md_done_i,
    input  logic [31:0]     md_result_i,
    output logic            rf_wr_en_o,
    output logic [4:0]      rf_wr_addr_o,
    output logic [31:0]     rf_wr_data_o,
    output logic            busy_o,
    output logic            done_o,
    output rv_pkg::retire_t retire_o
);

    import rv_pkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, MULDIV, WRITEBACK} state_e;

    state_e      state_q;
    decode_t     dec_q;
    logic [31:0] result_q;
    logic        accept;

    // WRITEBACK is not busy, so the next instruction can overlap it
    assign busy_o = (state_q == EXEC) || (state_q == MULDIV);
    assign accept = instr_valid_i && !busy_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                EXEC:    state_q <= dec_q.is_muldiv ? MULDIV : WRITEBACK;
                MULDIV:  state_q <= md_done_i ? WRITEBACK : MULDIV;
                default: state_q <= accept ? EXEC : IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_q <= decode_i;
        end
        if (state_q == EXEC) begin
            result_q <= dec_q.illegal ? 32'd0 : alu_result_i;
        end else if (state_q == MULDIV && md_done_i) begin
            result_q <= md_result_i;
        end
    end

    assign rs1_addr_o = dec_q.rs1;
    assign rs2_addr_o = dec_q.rs2;
    assign alu_op_o   = dec_q.alu_op;
    assign op_a_o     = (dec_q.src_sel == IMM_ZERO) ? 32'd0 : rs1_data_i;
    assign op_b_o     = (dec_q.src_sel == RS2_RS1) ? rs2_data_i : dec_q.imm;
    assign md_start_o = (state_q == EXEC) && dec_q.is_muldiv;

    assign done_o       = (state_q == WRITEBACK);
    assign rf_wr_en_o   = done_o && dec_q.wr_en;
    assign rf_wr_addr_o = dec_q.rd;
    assign rf_wr_data_o = result_q;

    assign retire_o.rd      = dec_q.rd;
    assign retire_o.value   = result_q;
    assign retire_o.illegal = dec_q.illegal;

endmodule

// ==== design/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            start_i,
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     op_a_i,
    input  logic [31:0]     op_b_i,
    output logic            done_o,
    output logic [31:0]     result_o
);

    import rv_pkg::*;

    logic        a_neg, b_neg;
    logic [31:0] a_mag, b_mag;
    logic        run_q;
    logic [4:0]  step_q;
    alu_op_e     op_q;
    logic        is_div_q, neg_res_q, neg_rem_q, div_zero_q;
    // Product, or remainder in the upper word and quotient in the lower
    logic [63:0] acc_q;
    logic [31:0] opnd_q;
    logic [32:0] mul_sum;
    logic [32:0] rem_shift;
    logic [33:0] rem_diff;
    logic [63:0] prod_fix;
    logic [31:0] quot_fix, rem_fix;

    // Operand signedness by op
    assign a_neg = op_a_i[31] && (op_i inside {ALU_MULH, ALU_MULHSU, ALU_DIV, ALU_REM});
    assign b_neg = op_b_i[31] && (op_i inside {ALU_MULH, ALU_DIV, ALU_REM});
    assign a_mag = a_neg ? (32'd0 - op_a_i) : op_a_i;
    assign b_mag = b_neg ? (32'd0 - op_b_i) : op_b_i;

    assign mul_sum   = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, opnd_q} : 33'd0);
    assign rem_shift = acc_q[63:31];
    assign rem_diff  = {1'b0, rem_shift} - {2'b00, opnd_q};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q  <= 1'b0;
            step_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                run_q  <= 1'b1;
                step_q <= '0;
            end else if (run_q) begin
                step_q <= step_q + 5'd1;
                if (step_q == 5'd31) begin
                    run_q  <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op_q       <= op_i;
            is_div_q   <= (op_i >= ALU_DIV);
            neg_res_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            div_zero_q <= (op_b_i == 32'd0);
            if (op_i >= ALU_DIV) begin
                acc_q  <= {32'd0, a_mag};
                opnd_q <= b_mag;
            end else begin
                acc_q  <= {32'd0, b_mag};
                opnd_q <= a_mag;
            end
        end else if (run_q) begin
            if (!is_div_q) begin
                acc_q <= {mul_sum, acc_q[31:1]};
            end else if (!rem_diff[33]) begin
                acc_q <= {rem_diff[31:0], acc_q[30:0], 1'b1};
            end else begin
                acc_q <= {rem_shift[31:0], acc_q[30:0], 1'b0};
            end
        end
    end

    assign prod_fix = neg_res_q ? (64'd0 - acc_q) : acc_q;
    assign rem_fix  = neg_rem_q ? (32'd0 - acc_q[63:32]) : acc_q[63:32];

    always_comb begin
        if (div_zero_q) begin
            quot_fix = '1;
        end else begin
            quot_fix = neg_res_q ? (32'd0 - acc_q[31:0]) : acc_q[31:0];
        end
        case (op_q)
            ALU_MUL:                        result_o = prod_fix[31:0];
            ALU_MULH, ALU_MULHSU, ALU_MULHU: result_o = prod_fix[63:32];
            ALU_DIV, ALU_DIVU:              result_o = quot_fix;
            default:                        result_o = rem_fix;
        endcase
    end

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     op_a_i,
    input  logic [31:0]     op_b_i,
    output logic [31:0]     result_o
);

    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = op_a_i + op_b_i;
            ALU_SUB:  result_o = op_a_i - op_b_i;
            ALU_SSL:  result_o = op_a_i << shamt;
            ALU_SRL:  result_o = op_a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(op_a_i) >>> shamt);
            ALU_SLT:  result_o = {31'd0, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU: result_o = {31'd0, op_a_i < op_b_i};
            ALU_XOR:  result_o = op_a_i ^ op_b_i;
            ALU_OR:   result_o = op_a_i | op_b_i;
            ALU_AND:  result_o = op_a_i & op_b_i;
            // M extension ops belong to the multiply/divide unit
            default:  result_o = 32'd0;
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  rd_addr1_i,
    input  logic [4:0]  rd_addr2_i,
    output logic [31:0] rd_data1_o,
    output logic [31:0] rd_data2_o,
    input  logic        wr_en_i,
    input  logic [4:0]  wr_addr_i,
    input  logic [31:0] wr_data_i
);

    // x0 has no storage
    logic [31:0] regs_q [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data1_o = (rd_addr1_i == 5'd0) ? 32'd0 : regs_q[rd_addr1_i];
    assign rd_data2_o = (rd_addr2_i == 5'd0) ? 32'd0 : regs_q[rd_addr2_i];

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic [31:0]     instruction_i,
    output rv_pkg::decode_t decode_o
);

    import rv_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign imm_i  = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_u  = {instruction_i[31:12], 12'b0};

    always_comb begin
        decode_o         = '0;
        decode_o.alu_op  = ALU_ADD;
        decode_o.src_sel = RS2_RS1;
        decode_o.rs1     = instruction_i[19:15];
        decode_o.rs2     = instruction_i[24:20];
        decode_o.rd      = instruction_i[11:7];

        case (opcode)
            OPCODE_IMM_ARITH: begin
                decode_o.src_sel = IMM_RS1;
                decode_o.imm     = imm_i;
                decode_o.wr_en   = 1'b1;
                case (funct3)
                    FUNCT3_ADD_SUB: decode_o.alu_op = ALU_ADD;
                    FUNCT3_SLT:     decode_o.alu_op = ALU_SLT;
                    FUNCT3_SLTU:    decode_o.alu_op = ALU_SLTU;
                    FUNCT3_XOR:     decode_o.alu_op = ALU_XOR;
                    FUNCT3_OR:      decode_o.alu_op = ALU_OR;
                    FUNCT3_AND:     decode_o.alu_op = ALU_AND;
                    // Shift amount is only the low five bits
                    FUNCT3_SLL: begin
                        decode_o.alu_op  = ALU_SSL;
                        decode_o.imm     = imm_i & 32'h1f;
                        decode_o.illegal = (funct7 != FUNCT7_ADD);
                    end
                    default: begin
                        decode_o.imm = imm_i & 32'h1f;
                        if (funct7 == FUNCT7_ADD) begin
                            decode_o.alu_op = ALU_SRL;
                        end else if (funct7 == FUNCT7_SUB) begin
                            decode_o.alu_op = ALU_SRA;
                        end else begin
                            decode_o.illegal = 1'b1;
                        end
                    end
                endcase
            end

            OPCODE_ARITH: begin
                decode_o.wr_en = 1'b1;
                case (funct7)
                    FUNCT7_ADD: begin
                        case (funct3)
                            FUNCT3_ADD_SUB: decode_o.alu_op = ALU_ADD;
                            FUNCT3_SLL:     decode_o.alu_op = ALU_SSL;
                            FUNCT3_SLT:     decode_o.alu_op = ALU_SLT;
                            FUNCT3_SLTU:    decode_o.alu_op = ALU_SLTU;
                            FUNCT3_XOR:     decode_o.alu_op = ALU_XOR;
                            FUNCT3_SRL_SRA: decode_o.alu_op = ALU_SRL;
                            FUNCT3_OR:      decode_o.alu_op = ALU_OR;
                            default:        decode_o.alu_op = ALU_AND;
                        endcase
                    end
                    FUNCT7_SUB: begin
                        if (funct3 == FUNCT3_ADD_SUB) begin
                            decode_o.alu_op = ALU_SUB;
                        end else if (funct3 == FUNCT3_SRL_SRA) begin
                            decode_o.alu_op = ALU_SRA;
                        end else begin
                            decode_o.illegal = 1'b1;
                        end
                    end
                    FUNCT7_MUL_DIV_REM: begin
                        case (funct3)
                            FUNCT3_MUL:    decode_o.alu_op = ALU_MUL;
                            FUNCT3_MULH:   decode_o.alu_op = ALU_MULH;
                            FUNCT3_MULHSU: decode_o.alu_op = ALU_MULHSU;
                            FUNCT3_MULHU:  decode_o.alu_op = ALU_MULHU;
                            FUNCT3_DIV:    decode_o.alu_op = ALU_DIV;
                            FUNCT3_DIVU:   decode_o.alu_op = ALU_DIVU;
                            FUNCT3_REM:    decode_o.alu_op = ALU_REM;
                            default:       decode_o.alu_op = ALU_REMU;
                        endcase
                    end
                    default: decode_o.illegal = 1'b1;
                endcase
            end

            OPCODE_LUI: begin
                decode_o.src_sel = IMM_ZERO;
                decode_o.imm     = imm_u;
                decode_o.wr_en   = 1'b1;
            end

            // Loads, stores, jumps, branches, SYSTEM, FENCE
            default: decode_o.illegal = 1'b1;
        endcase

        if (decode_o.illegal) begin
            decode_o.alu_op = ALU_ADD;
            decode_o.wr_en  = 1'b0;
        end
        decode_o.is_muldiv = (decode_o.alu_op >= ALU_MUL);
    end

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    // Major opcodes handled by the execute subsystem
    localparam logic [6:0] OPCODE_IMM_ARITH = 7'b0010011;
    localparam logic [6:0] OPCODE_ARITH     = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI       = 7'b0110111;

    // funct3 shared by OP and OP-IMM
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct3 under the M extension
    localparam logic [2:0] FUNCT3_MUL    = 3'b000;
    localparam logic [2:0] FUNCT3_MULH   = 3'b001;
    localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
    localparam logic [2:0] FUNCT3_MULHU  = 3'b011;
    localparam logic [2:0] FUNCT3_DIV    = 3'b100;
    localparam logic [2:0] FUNCT3_DIVU   = 3'b101;
    localparam logic [2:0] FUNCT3_REM    = 3'b110;
    localparam logic [2:0] FUNCT3_REMU   = 3'b111;

    localparam logic [6:0] FUNCT7_ADD         = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB         = 7'b0100000;
    localparam logic [6:0] FUNCT7_MUL_DIV_REM = 7'b0000001;

    // Everything from ALU_MUL on runs in the multiply/divide unit
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SSL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [1:0] {
        RS2_RS1,
        IMM_RS1,
        IMM_ZERO
    } src_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        src_sel_e    src_sel;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        wr_en;
        logic        is_muldiv;
        logic        illegal;
    } decode_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        illegal;
    } retire_t;

endpackage
